// ==== design/busPhaseGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module busPhaseGen import memBusPkg::*; #(
  parameter int PHASE_LEN = 2
) (
  input  logic      clk,
  input  logic      reset,
  output busPhase_e phase,
  output logic      aChangeComing,
  output logic      bChangeComing
);

  localparam int CNT_W = $clog2(PHASE_LEN);

  logic [CNT_W-1:0] phaseCnt;
  logic             lastCycle;
  logic             preLastCycle;

  assign lastCycle = (phaseCnt == CNT_W'(PHASE_LEN - 1));

  // Strobes are loaded here so they sit on the last cycle of the phase
  assign preLastCycle = (phaseCnt == CNT_W'(PHASE_LEN - 2));

  always_ff @(posedge clk) begin
    if (reset) begin
      phaseCnt      <= '0;
      phase         <= PHASE_A;
      aChangeComing <= 1'b0;
      bChangeComing <= 1'b0;
    end else begin
      if (lastCycle) begin
        phaseCnt <= '0;
        phase    <= (phase == PHASE_A) ? PHASE_B : PHASE_A;
      end else begin
        phaseCnt <= phaseCnt + CNT_W'(1);
      end
      // A is coming while B runs, and the other way round
      aChangeComing <= preLastCycle && (phase == PHASE_B);
      bChangeComing <= preLastCycle && (phase == PHASE_A);
    end
  end

endmodule

`default_nettype wire

// ==== design/coreReadTrack.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreReadTrack import memReqPkg::*, memBusPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       aChangeComing,
  input  logic       bChangeComing,
  input  busResp_t   busResp,
  input  logic       rdStart,
  input  logic [3:0] startMask,
  input  logic [1:0] startWord,
  input  logic       lastAckn,
  output logic       respValid,
  output coreResp_t  resp,
  output logic       drained
);

  logic        validM2;
  logic        validM1;
  logic [35:0] dataM1;
  logic [35:0] respData;
  logic [3:0]  wordsLeft;
  logic [3:0]  wordsLeftNext;
  logic [1:0]  curIdx;
  logic        rdActive;
  logic        acknSeen;

  // First set mask bit at or after from, wrapping mod 4
  function automatic logic [1:0] nextSetWord(input logic [3:0] mask,
                                             input logic [1:0] from);
    logic [1:0] idx;
    logic [1:0] pick;
    pick = from;
    for (int k = 3; k >= 0; k--) begin
      idx = from + 2'(k);
      if (mask[idx]) begin
        pick = idx;
      end
    end
    return pick;
  endfunction

  assign validM2 = (busResp.dataValidA & aChangeComing) |
                   (busResp.dataValidB & bChangeComing);

  assign wordsLeftNext = wordsLeft & ~(4'b0001 << curIdx);

  assign resp = '{data: respData, wordIdx: curIdx};

  assign drained = acknSeen & ~rdActive & ~validM1 & ~respValid;

  always_ff @(posedge clk) begin
    if (validM2) begin
      dataM1 <= busResp.data;
    end
    if (validM1) begin
      respData <= dataM1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      validM1   <= 1'b0;
      respValid <= 1'b0;
      wordsLeft <= 4'b0000;
      curIdx    <= 2'd0;
      rdActive  <= 1'b0;
      acknSeen  <= 1'b0;
    end else begin
      validM1   <= validM2;
      respValid <= validM1;
      if (rdStart) begin
        wordsLeft <= startMask;
        curIdx    <= nextSetWord(startMask, startWord);
        rdActive  <= 1'b1;
        acknSeen  <= 1'b0;
      end else begin
        if (lastAckn) begin
          acknSeen <= 1'b1;
        end
        // Advance past the word just handed back
        if (respValid && rdActive) begin
          wordsLeft <= wordsLeftNext;
          curIdx    <= nextSetWord(wordsLeftNext, curIdx + 2'd1);
          if (wordsLeftNext == 4'b0000) begin
            rdActive <= 1'b0;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/memBusPkg.sv ====
`default_nettype none

package memBusPkg;

  typedef enum logic {
    PHASE_A = 1'b0,
    PHASE_B = 1'b1
  } busPhase_e;

  // Controller to memory
  typedef struct packed {
    logic        startA;
    logic        startB;
    logic        rdRq;
    logic        wrRq;
    logic [3:0]  rq;
    logic [21:0] adr;
    logic        adrPar;
  } busReq_t;

  // Memory to controller
  typedef struct packed {
    logic        acknA;
    logic        acknB;
    logic        dataValidA;
    logic        dataValidB;
    logic [35:0] data;
  } busResp_t;

endpackage

`default_nettype wire

// ==== design/memCtlTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module memCtlTop import memReqPkg::*, memBusPkg::*; #(
  parameter int PHASE_LEN = 2
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      reqValid,
  output logic      reqReady,
  input  coreReq_t  req,
  output logic      respValid,
  output coreResp_t resp,
  output busReq_t   busReq,
  input  busResp_t  busResp,
  output logic      done
);

  busPhase_e  phase;
  logic       aChangeComing;
  logic       bChangeComing;
  logic       rdStart;
  logic [3:0] startMask;
  logic [1:0] startWord;
  logic       lastAckn;
  logic       drained;

  busPhaseGen #(
    .PHASE_LEN(PHASE_LEN)
  ) phaseGen (
    .clk          (clk),
    .reset        (reset),
    .phase        (phase),
    .aChangeComing(aChangeComing),
    .bChangeComing(bChangeComing)
  );

  memStartCtl startCtl (
    .clk          (clk),
    .reset        (reset),
    .reqValid     (reqValid),
    .reqReady     (reqReady),
    .req          (req),
    .phase        (phase),
    .aChangeComing(aChangeComing),
    .bChangeComing(bChangeComing),
    .busResp      (busResp),
    .busReq       (busReq),
    .rdStart      (rdStart),
    .startMask    (startMask),
    .startWord    (startWord),
    .lastAckn     (lastAckn),
    .drained      (drained),
    .done         (done)
  );

  coreReadTrack readTrack (
    .clk          (clk),
    .reset        (reset),
    .aChangeComing(aChangeComing),
    .bChangeComing(bChangeComing),
    .busResp      (busResp),
    .rdStart      (rdStart),
    .startMask    (startMask),
    .startWord    (startWord),
    .lastAckn     (lastAckn),
    .respValid    (respValid),
    .resp         (resp),
    .drained      (drained)
  );

endmodule

`default_nettype wire

// ==== design/memReqPkg.sv ====
`default_nettype none

package memReqPkg;

  // One bit per word of the quad
  typedef logic [3:0] wordMask_t;

  // Word position inside the quad
  typedef logic [1:0] wordIdx_t;

  typedef struct packed {
    logic [21:0] addr;
    wordMask_t   rqMask;
    logic        isWrite;
    logic        forceBadPar;
  } coreReq_t;

  // Returned read word
  typedef struct packed {
    logic [35:0] data;
    wordIdx_t    wordIdx;
  } coreResp_t;

  typedef enum logic [1:0] {
    IDLE       = 2'd0,
    WAIT_PHASE = 2'd1,
    STARTED    = 2'd2,
    DRAIN      = 2'd3
  } ctlState_e;

endpackage

`default_nettype wire

// ==== design/memStartCtl.sv ====
`timescale 1ns/1ps
`default_nettype none

module memStartCtl import memReqPkg::*, memBusPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       reqValid,
  output logic       reqReady,
  input  coreReq_t   req,
  input  busPhase_e  phase,
  input  logic       aChangeComing,
  input  logic       bChangeComing,
  input  busResp_t   busResp,
  output busReq_t    busReq,
  output logic       rdStart,
  output logic [3:0] startMask,
  output logic [1:0] startWord,
  output logic       lastAckn,
  input  logic       drained,
  output logic       done
);

  ctlState_e   state;
  coreReq_t    reqHold;
  logic        startA;
  logic        startB;
  logic        startUp;
  logic        changeComing;
  logic        ackPulse;
  logic [3:0]  rqLeft;
  logic [3:0]  rqLeftNext;
  logic        rdRq;
  logic        wrRq;
  logic [3:0]  rqLines;
  logic [21:0] adrLines;
  logic        oddPar;

  assign reqReady     = (state == IDLE);
  assign changeComing = aChangeComing | bChangeComing;
  assign startUp      = startA | startB;

  // Acks only count on the started phase's change-coming cycle
  assign ackPulse = (startA & aChangeComing & busResp.acknA) |
                    (startB & bChangeComing & busResp.acknB);

  // Drop the lowest outstanding word
  assign rqLeftNext = rqLeft & (rqLeft - 4'd1);
  assign lastAckn   = ackPulse & (rqLeftNext == 4'd0);

  assign rdStart   = (state == WAIT_PHASE) & changeComing & ~reqHold.isWrite;
  assign startMask = reqHold.rqMask;
  assign startWord = reqHold.addr[1:0];

  assign done = (state == DRAIN) & (reqHold.isWrite | drained);

  // Request lines held only while the start is up
  assign rdRq     = startUp & ~reqHold.isWrite;
  assign wrRq     = startUp & reqHold.isWrite;
  assign rqLines  = startUp ? reqHold.rqMask : 4'b0000;
  assign adrLines = startUp ? reqHold.addr : 22'd0;
  assign oddPar   = ~(^{adrLines, rqLines, rdRq, wrRq});

  always_comb begin
    busReq.startA = startA;
    busReq.startB = startB;
    busReq.rdRq   = rdRq;
    busReq.wrRq   = wrRq;
    busReq.rq     = rqLines;
    busReq.adr    = adrLines;
    // Forced bad parity lasts for this one transaction
    busReq.adrPar = oddPar ^ (startUp & reqHold.forceBadPar);
  end

  always_ff @(posedge clk) begin
    if (reqValid && reqReady) begin
      reqHold <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= IDLE;
      startA <= 1'b0;
      startB <= 1'b0;
      rqLeft <= 4'b0000;
    end else begin
      case (state)
        IDLE: begin
          if (reqValid) begin
            state <= WAIT_PHASE;
          end
        end
        WAIT_PHASE: begin
          if (changeComing) begin
            // Start lands on the phase about to begin
            startA <= (phase == PHASE_B);
            startB <= (phase == PHASE_A);
            rqLeft <= reqHold.rqMask;
            state  <= STARTED;
          end
        end
        STARTED: begin
          if (ackPulse) begin
            rqLeft <= rqLeftNext;
          end
          if (lastAckn) begin
            startA <= 1'b0;
            startB <= 1'b0;
            state  <= DRAIN;
          end
        end
        DRAIN: begin
          if (done) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
design/memReqPkg.sv
design/memBusPkg.sv
design/busPhaseGen.sv
design/memStartCtl.sv
design/coreReadTrack.sv
design/memCtlTop.sv
sim/memCtl_assert.sv
sim/memCtlTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the memory controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f project.f \
  --top-module memCtlTb \
  --Mdir obj_dir \
  -o memCtlSim \
  && ./obj_dir/memCtlSim | tee /dev/stderr | grep -q "STATUS: PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== sim/memCtlTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module memCtlTb import memReqPkg::*, memBusPkg::*;;

  localparam int PHASE_LEN = 2;
  localparam int NUM_ROWS = 8;
  localparam int PERIOD = 40;

  // One transaction and its expected acknowledgement count
  typedef struct packed {
    coreReq_t   req;
    logic [2:0] acks;
  } stimRow_t;

  logic      clk = 1'b0;
  logic      reset = 1'b1;
  logic      reqValid = 1'b0;
  logic      reqReady;
  coreReq_t  req = '0;
  logic      respValid;
  coreResp_t resp;
  busReq_t   busReq;
  busResp_t  busResp = '0;
  logic      done;

  stimRow_t  rows [NUM_ROWS];
  coreResp_t respQ [$];
  int        errors = 0;
  int        checks = 0;
  int        xferCount = 0;
  int        doneCount = 0;
  int        ackCount = 0;
  logic      timedOut = 1'b0;
  logic [31:0] gapLfsr = 32'h41ae_463b;
  logic [31:0] memLfsr = 32'h41ae_463b;

  memCtlTop #(
    .PHASE_LEN(PHASE_LEN)
  ) dut (
    .clk      (clk),
    .reset    (reset),
    .reqValid (reqValid),
    .reqReady (reqReady),
    .req      (req),
    .respValid(respValid),
    .resp     (resp),
    .busReq   (busReq),
    .busResp  (busResp),
    .done     (done)
  );

  always #20 clk = ~clk;

  // Galois LFSR step
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'hA300_0000 : 32'h0);
  endfunction

  // Idle gap of 0 to 3 cycles from two LFSR bits
  task automatic drawGap(output int g);
    logic hiBit;
    hiBit = gapLfsr[0];
    gapLfsr = lfsrStep(gapLfsr);
    g = {30'd0, hiBit, gapLfsr[0]};
    gapLfsr = lfsrStep(gapLfsr);
  endtask

  function automatic logic [35:0] wordPattern(input logic [21:0] addr, input logic [1:0] idx);
    return {4'ha, idx, 8'h3c, addr ^ {20'd0, idx}};
  endfunction

  // First requested word at or after from with wraparound
  function automatic logic [1:0] firstWordFrom(input logic [3:0] mask, input logic [1:0] from);
    logic [1:0] idx;
    for (int k = 0; k < 4; k++) begin
      idx = from + 2'(k);
      if (mask[idx]) begin
        return idx;
      end
    end
    return from;
  endfunction

  task automatic checkVal(input string name, input logic [63:0] expVal,
                          input logic [63:0] gotVal);
    checks++;
    assert (expVal === gotVal) else begin
      errors++;
      $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, expVal, gotVal);
    end
  endtask

  // Monitor of transfers, done pulses and returned words
  always @(posedge clk) begin
    if (!reset) begin
      if (reqValid && reqReady) xferCount++;
      if (done) doneCount++;
      if (respValid) respQ.push_back(resp);
    end
  end

  // Memory responder acting on the started phase's change-coming cycles
  int         cyc = 0;
  logic       curA;
  logic       curB;
  logic       prevA = 1'b0;
  logic       prevB = 1'b0;
  logic       memActive = 1'b0;
  logic       memRead;
  logic       skipped;
  logic       ackNow;
  logic [3:0] memLeft;
  logic [1:0] memIdx;
  logic [21:0] memAdr;
  busResp_t   nextResp;

  always @(posedge clk) begin
    if (reset) begin
      cyc = 0;
      memActive = 1'b0;
      busResp <= '0;
    end else begin
      curA = (cyc % (2 * PHASE_LEN)) == 2 * PHASE_LEN - 1;
      curB = (cyc % (2 * PHASE_LEN)) == PHASE_LEN - 1;
      cyc++;
      if (!(busReq.startA || busReq.startB)) begin
        memActive = 1'b0;
      end else if (!memActive ||
                   (busReq.startA && curA) || (busReq.startB && curB)) begin
        if (!memActive) begin
          assert ((busReq.startA && prevA) || (busReq.startB && prevB)) else begin
            errors++;
            $display("Start rose at %0t without the matching change-coming strobe", $time);
          end
          memActive = 1'b1;
          memLeft = busReq.rq;
          memIdx = firstWordFrom(busReq.rq, busReq.adr[1:0]);
          memRead = busReq.rdRq;
          memAdr = busReq.adr;
          ackCount = 0;
          skipped = 1'b0;
        end else if (busResp.acknA || busResp.acknB) begin
          ackCount++;
          memLeft[memIdx] = 1'b0;
          memIdx = firstWordFrom(memLeft, memIdx + 2'd1);
        end
        nextResp = '0;
        if (memLeft != 4'b0000) begin
          // At most one phase of delay per word
          ackNow = skipped | ~memLfsr[0];
          memLfsr = lfsrStep(memLfsr);
          skipped = ~ackNow;
          nextResp.acknA = busReq.startA & ackNow;
          nextResp.acknB = busReq.startB & ackNow;
          nextResp.dataValidA = busReq.startA & ackNow & memRead;
          nextResp.dataValidB = busReq.startB & ackNow & memRead;
          nextResp.data = wordPattern(memAdr, memIdx);
        end
        busResp <= nextResp;
      end
      prevA = curA;
      prevB = curB;
    end
  end

  initial begin
    int gap;
    int waitCnt;
    int expWords;
    logic holding;
    logic seenStart;
    logic expPar;
    logic [1:0] idx;
    time xferTime;
    coreReq_t row;
    coreResp_t got;

    rows[0] = '{'{22'h012345, 4'hf, 1'b0, 1'b0}, 3'd4};
    rows[1] = '{'{22'h00abc2, 4'h5, 1'b0, 1'b0}, 3'd2};
    rows[2] = '{'{22'h3ffff3, 4'h9, 1'b1, 1'b0}, 3'd2};
    rows[3] = '{'{22'h100001, 4'ha, 1'b0, 1'b1}, 3'd2};
    rows[4] = '{'{22'h055550, 4'h1, 1'b1, 1'b0}, 3'd1};
    rows[5] = '{'{22'h2aaaa7, 4'he, 1'b1, 1'b1}, 3'd3};
    rows[6] = '{'{22'h000002, 4'h3, 1'b0, 1'b0}, 3'd2};
    rows[7] = '{'{22'h1c3c3d, 4'h8, 1'b0, 1'b0}, 3'd1};

    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    checkVal("busReq.startA", 64'(0), 64'(busReq.startA));
    checkVal("busReq.startB", 64'(0), 64'(busReq.startB));
    checkVal("respValid", 64'(0), 64'(respValid));
    checkVal("done", 64'(0), 64'(done));
    checkVal("reqReady", 64'(1), 64'(reqReady));

    holding = 1'b0;
    drawGap(gap);
    for (int i = 0; i < NUM_ROWS; i++) begin
      row = rows[i].req;
      if (!holding) begin
        repeat (gap) @(posedge clk);
        reqValid <= 1'b1;
        req <= row;
      end
      waitCnt = 0;
      do begin
        @(posedge clk);
        waitCnt++;
      end while (!(reqValid && reqReady) && waitCnt < 100);
      if (!(reqValid && reqReady)) begin
        $display("Timeout while waiting for the transfer of row %0d", i);
        timedOut = 1'b1;
        break;
      end
      xferTime = $time;
      drawGap(gap);
      // Next request stays up through the busy period when there is no gap
      if (gap == 0 && i + 1 < NUM_ROWS) begin
        req <= rows[i + 1].req;
        holding = 1'b1;
      end else begin
        reqValid <= 1'b0;
        holding = 1'b0;
      end

      // Exactly one of rdRq and wrRq is up during a start
      expPar = (^{row.addr, row.rqMask}) ^ row.forceBadPar;
      seenStart = 1'b0;
      waitCnt = 0;
      do begin
        @(posedge clk);
        waitCnt++;
        if (busReq.startA || busReq.startB) begin
          if (!seenStart) begin
            seenStart = 1'b1;
            assert (($time - PERIOD - xferTime) <= PHASE_LEN * PERIOD &&
                    ($time - PERIOD - xferTime) >= PERIOD) else begin
              errors++;
              $display("Start latency out of range for row %0d", i);
            end
          end
          checkVal("busReq.rq", 64'(row.rqMask), 64'(busReq.rq));
          checkVal("busReq.adr", 64'(row.addr), 64'(busReq.adr));
          checkVal("busReq.rdRq", 64'(!row.isWrite), 64'(busReq.rdRq));
          checkVal("busReq.wrRq", 64'(row.isWrite), 64'(busReq.wrRq));
          checkVal("busReq.adrPar", 64'(expPar), 64'(busReq.adrPar));
        end
      end while (!done && waitCnt < 400);
      if (!done) begin
        $display("Timeout while waiting for done of row %0d", i);
        timedOut = 1'b1;
        break;
      end

      checkVal("acknowledge count", 64'(rows[i].acks), 64'(ackCount));
      checkVal("transfer count", 64'(i + 1), 64'(xferCount));
      expWords = row.isWrite ? 0 : int'(rows[i].acks);
      checkVal("respValid word count", 64'(expWords), 64'(respQ.size()));
      if (!row.isWrite) begin
        for (int k = 0; k < 4; k++) begin
          idx = row.addr[1:0] + 2'(k);
          if (row.rqMask[idx] && respQ.size() > 0) begin
            got = respQ.pop_front();
            checkVal("resp.wordIdx", 64'(idx), 64'(got.wordIdx));
            checkVal("resp.data", 64'(wordPattern(row.addr, idx)), 64'(got.data));
          end
        end
      end
      respQ.delete();
    end

    if (!timedOut) begin
      repeat (4) @(posedge clk);
      checkVal("total transfers", 64'(NUM_ROWS), 64'(xferCount));
      checkVal("total done pulses", 64'(NUM_ROWS), 64'(doneCount));
    end
    $display("Checks run: %0d, errors: %0d, timeouts: %0d", checks, errors, timedOut);
    if (errors == 0 && !timedOut) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/memCtl_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module memCtlAssert import memReqPkg::*; (
  input logic     clk,
  input logic     reset,
  input logic     startA,
  input logic     startB,
  input logic     aChangeComing,
  input logic     bChangeComing,
  input logic     reqValid,
  input logic     reqReady,
  input coreReq_t req
);

  // High when the latest strobe was aChangeComing
  logic lastWasA;

  always_ff @(posedge clk) begin
    if (reset) begin
      lastWasA <= 1'b1;
    end else if (aChangeComing) begin
      lastWasA <= 1'b1;
    end else if (bChangeComing) begin
      lastWasA <= 1'b0;
    end
  end

  assert property (@(posedge clk) disable iff (reset) !(startA && startB))
    else $error("startA and startB high together");

  assert property (@(posedge clk) disable iff (reset) aChangeComing |=> !aChangeComing)
    else $error("aChangeComing wider than one cycle");

  assert property (@(posedge clk) disable iff (reset) bChangeComing |=> !bChangeComing)
    else $error("bChangeComing wider than one cycle");

  assert property (@(posedge clk) disable iff (reset) aChangeComing |-> !lastWasA)
    else $error("two aChangeComing strobes without bChangeComing between");

  assert property (@(posedge clk) disable iff (reset) bChangeComing |-> lastWasA)
    else $error("two bChangeComing strobes without aChangeComing between");

  assert property (@(posedge clk) disable iff (reset)
                   (reqValid && !reqReady) |=> (!reqValid || $stable(req)))
    else $error("req changed while waiting for reqReady");

endmodule

bind memStartCtl memCtlAssert chk (
  .clk          (clk),
  .reset        (reset),
  .startA       (startA),
  .startB       (startB),
  .aChangeComing(aChangeComing),
  .bChangeComing(bChangeComing),
  .reqValid     (reqValid),
  .reqReady     (reqReady),
  .req          (req)
);

`default_nettype wire
